// File: hw/CommandInterpreter_consts.svh
`ifndef COMMAND_INTERPRETER_CONSTS_SVH
`define COMMAND_INTERPRETER_CONSTS_SVH

// Command FIFO depth and pointer width
`define CMD_FIFO_DEPTH 16
`define CMD_FIFO_AW 4

// Front-end channel layout
`define NUM_CHANNELS 64
`define NUM_DISCRI 3

// Field addresses, matched against word bits 15..4
`define ADDR_DAC0_LO 12'hC00
`define ADDR_DAC0_MID 12'hC01
`define ADDR_DAC0_HI 12'hC02
`define ADDR_DAC1_LO 12'hC03
`define ADDR_DAC1_MID 12'hC04
`define ADDR_DAC1_HI 12'hC05
`define ADDR_DAC2_LO 12'hC06
`define ADDR_DAC2_MID 12'hC07
`define ADDR_DAC2_HI 12'hC08
`define ADDR_CHIPID_LO 12'hA1B
`define ADDR_CHIPID_HI 12'hA1C
`define ADDR_DATAOUT_SEL 12'hA0B
`define ADDR_TRANSMITON_SEL 12'hA0C
`define ADDR_CTEST_LO 12'hA16
`define ADDR_CTEST_HI 12'hA17
`define ADDR_MASKCH_LO 12'hA2A
`define ADDR_MASKCH_HI 12'hA2B
`define ADDR_DISCRI_PATTERN 12'hA2C
`define ADDR_MASK_ACTION 12'hA2D

// Top six bits of a channel adjust word, CC00 to CFFF
`define ADJUST_PREFIX 6'b110011

// Reset defaults
`define CHIPID_DEFAULT 8'hA1
`define DATAOUT_SEL_DEFAULT 2'd3
`define TRANSMITON_SEL_DEFAULT 2'd3

// CTest code that injects into every channel
`define CTEST_ALL 8'd255

`endif

// File: hw/CommandPkg.sv
package CommandPkg;

	////////////////////////////////////////////////////////////
	// Command word layout
	////////////////////////////////////////////////////////////

	// Full word as written by the host, WXYZ in hex
	typedef logic [15:0] commandWord_t;

	// WX address plus Y sub-address
	typedef logic [11:0] cmdAddr_t;

	// Z data field
	typedef logic [3:0] nibble_t;

	////////////////////////////////////////////////////////////
	// Reader to decoder strobe
	////////////////////////////////////////////////////////////

	// One-cycle pulse with the popped word
	// Never high on two back-to-back cycles
	typedef struct packed {
		logic Valid;
		commandWord_t Word;
	} cmdStrobe_t;

endpackage

// File: hw/SlowControlPkg.sv
`include "CommandInterpreter_consts.svh"

package SlowControlPkg;
	import CommandPkg::*;

	// Global ASIC parameters
	typedef logic [9:0] dacCode_t;
	typedef struct packed {
		dacCode_t Dac0;
		dacCode_t Dac1;
		dacCode_t Dac2;
	} dacVth_t;
	typedef logic [7:0] chipId_t;
	typedef logic [1:0] chSelect_t;

	// Per-channel addressing
	typedef logic [5:0] channelIdx_t;
	typedef logic [7:0] ctestCode_t;
	// One bit per discriminator, 1 is enabled
	typedef logic [`NUM_DISCRI-1:0] discriMask_t;

	// Broadcast operation to the channel slices
	typedef enum logic [2:0] {
		OpNone,
		OpSetAdjust,
		OpMask,
		OpUnmask,
		OpUnmaskAll
	} chanOpKind_t;

	typedef struct packed {
		chanOpKind_t Kind;
		channelIdx_t Channel;
		nibble_t Adjust;
		discriMask_t Pattern;
	} channelOp_t;

	// Command read FSM
	typedef enum logic {
		ReadIdle,
		ReadPop
	} readState_t;

endpackage

// File: hw/CommandReader.sv
`timescale 1ns/1ns
`include "CommandInterpreter_consts.svh"

module CommandReader
	import CommandPkg::*;
	import SlowControlPkg::*;
(
	input logic Clk,
	input logic reset_n,
	input logic CommandWordEn,
	input commandWord_t CommandWord,
	output logic CommandFifoFull,
	output cmdStrobe_t Cmd
);

	// Count needs one more bit than the pointers to reach full
	localparam int CountW = `CMD_FIFO_AW + 1;

	commandWord_t FifoMem [`CMD_FIFO_DEPTH];
	logic [`CMD_FIFO_AW-1:0] WrPtr;
	logic [`CMD_FIFO_AW-1:0] RdPtr;
	logic [CountW-1:0] FifoCount;
	logic FifoEmpty;
	logic FifoWrite;
	logic FifoPop;
	readState_t State;
	logic CmdValid;
	commandWord_t CmdWord;

	////////////////////////////////////////////////////////////
	// Command FIFO
	////////////////////////////////////////////////////////////

	assign FifoEmpty = (FifoCount == '0);
	assign CommandFifoFull = (FifoCount == CountW'(`CMD_FIFO_DEPTH));
	// Words offered while full are dropped
	assign FifoWrite = CommandWordEn && !CommandFifoFull;
	// Only the reader pops, and only after seeing data
	assign FifoPop = (State == ReadPop);

	always_ff @(posedge Clk) begin
		if (FifoWrite) begin
			FifoMem[WrPtr] <= CommandWord;
		end
	end

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			WrPtr <= '0;
			RdPtr <= '0;
			FifoCount <= '0;
		end else begin
			// Pointers wrap naturally at the depth
			if (FifoWrite) begin
				WrPtr <= WrPtr + 1'b1;
			end
			if (FifoPop) begin
				RdPtr <= RdPtr + 1'b1;
			end
			case ({FifoWrite, FifoPop})
				2'b10: FifoCount <= FifoCount + 1'b1;
				2'b01: FifoCount <= FifoCount - 1'b1;
				default: FifoCount <= FifoCount;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read FSM, one word every two cycles
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			State <= ReadIdle;
		end else begin
			case (State)
				ReadIdle: begin
					if (!FifoEmpty) begin
						State <= ReadPop;
					end
				end
				// Pop and present, then back to idle
				ReadPop: State <= ReadIdle;
				default: State <= ReadIdle;
			endcase
		end
	end

	// Strobe follows the pop by one edge
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			CmdValid <= 1'b0;
		end else begin
			CmdValid <= FifoPop;
		end
	end

	// Head word captured as it leaves
	always_ff @(posedge Clk) begin
		if (FifoPop) begin
			CmdWord <= FifoMem[RdPtr];
		end
	end

	assign Cmd = '{Valid: CmdValid, Word: CmdWord};

endmodule

// File: hw/CommandDecoder.sv
`timescale 1ns/1ns
`include "CommandInterpreter_consts.svh"

module CommandDecoder
	import CommandPkg::*;
	import SlowControlPkg::*;
(
	input logic Clk,
	input logic reset_n,
	input cmdStrobe_t Cmd,
	output dacVth_t DacVth,
	output chipId_t ChipId,
	output chSelect_t DataoutChannelSelect,
	output chSelect_t TransmitOnChannelSelect,
	output ctestCode_t CTestCode,
	output channelOp_t ChanOp
);

	cmdAddr_t CmdAddr;
	nibble_t CmdData;
	logic IsAdjust;
	channelIdx_t MaskChannel;
	discriMask_t DiscriPattern;
	chanOpKind_t NextOpKind;
	chanOpKind_t OpKind;
	channelIdx_t OpChannel;
	nibble_t OpAdjust;
	discriMask_t OpPattern;

	// Split the word into address and data
	assign CmdAddr = Cmd.Word[15:4];
	assign CmdData = Cmd.Word[3:0];
	// Adjust words carry the channel in bits 9..4
	assign IsAdjust = Cmd.Valid && (Cmd.Word[15:10] == `ADJUST_PREFIX);

	////////////////////////////////////////////////////////////
	// Global field registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			DacVth <= '0;
			ChipId <= `CHIPID_DEFAULT;
			DataoutChannelSelect <= `DATAOUT_SEL_DEFAULT;
			TransmitOnChannelSelect <= `TRANSMITON_SEL_DEFAULT;
			CTestCode <= '0;
			MaskChannel <= '0;
			DiscriPattern <= '0;
		end else if (Cmd.Valid) begin
			case (CmdAddr)
				// DAC thresholds, three nibble slices each
				`ADDR_DAC0_LO: DacVth.Dac0[3:0] <= CmdData;
				`ADDR_DAC0_MID: DacVth.Dac0[7:4] <= CmdData;
				`ADDR_DAC0_HI: DacVth.Dac0[9:8] <= CmdData[1:0];
				`ADDR_DAC1_LO: DacVth.Dac1[3:0] <= CmdData;
				`ADDR_DAC1_MID: DacVth.Dac1[7:4] <= CmdData;
				`ADDR_DAC1_HI: DacVth.Dac1[9:8] <= CmdData[1:0];
				`ADDR_DAC2_LO: DacVth.Dac2[3:0] <= CmdData;
				`ADDR_DAC2_MID: DacVth.Dac2[7:4] <= CmdData;
				`ADDR_DAC2_HI: DacVth.Dac2[9:8] <= CmdData[1:0];
				// Chip ID
				`ADDR_CHIPID_LO: ChipId[3:0] <= CmdData;
				`ADDR_CHIPID_HI: ChipId[7:4] <= CmdData;
				// Output channel selects, low two bits
				`ADDR_DATAOUT_SEL: DataoutChannelSelect <= CmdData[1:0];
				`ADDR_TRANSMITON_SEL: TransmitOnChannelSelect <= CmdData[1:0];
				// Charge injection code, decoded in the slices
				`ADDR_CTEST_LO: CTestCode[3:0] <= CmdData;
				`ADDR_CTEST_HI: CTestCode[7:4] <= CmdData;
				// Mask target and pattern, used by the next action
				`ADDR_MASKCH_LO: MaskChannel[3:0] <= CmdData;
				`ADDR_MASKCH_HI: MaskChannel[5:4] <= CmdData[1:0];
				`ADDR_DISCRI_PATTERN: DiscriPattern <= CmdData[`NUM_DISCRI-1:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Channel operation broadcast
	////////////////////////////////////////////////////////////

	always_comb begin
		NextOpKind = OpNone;
		if (IsAdjust) begin
			NextOpKind = OpSetAdjust;
		end else if (Cmd.Valid && (CmdAddr == `ADDR_MASK_ACTION)) begin
			// Unlisted action codes do nothing
			case (CmdData)
				4'd0: NextOpKind = OpUnmaskAll;
				4'd1: NextOpKind = OpMask;
				4'd2: NextOpKind = OpUnmask;
				default: NextOpKind = OpNone;
			endcase
		end
	end

	// Kind lasts exactly one cycle
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			OpKind <= OpNone;
		end else begin
			OpKind <= NextOpKind;
		end
	end

	// Operands only matter while Kind is set
	always_ff @(posedge Clk) begin
		if (IsAdjust) begin
			OpChannel <= Cmd.Word[9:4];
			OpAdjust <= CmdData;
		end else begin
			OpChannel <= MaskChannel;
		end
		OpPattern <= DiscriPattern;
	end

	assign ChanOp = '{
		Kind: OpKind,
		Channel: OpChannel,
		Adjust: OpAdjust,
		Pattern: OpPattern
	};

endmodule

// File: hw/ChannelSlice.sv
`timescale 1ns/1ns
`include "CommandInterpreter_consts.svh"

module ChannelSlice
	import CommandPkg::*;
	import SlowControlPkg::*;
#(
	parameter int ChannelIndex = 0
)(
	input logic Clk,
	input logic reset_n,
	input channelOp_t ChanOp,
	input ctestCode_t CTestCode,
	output nibble_t Adjust,
	output discriMask_t Mask,
	output logic CTestSelect
);

	// This slice's address and its CTest code, k selects channel k-1
	localparam channelIdx_t MyChannel = channelIdx_t'(ChannelIndex);
	localparam ctestCode_t MyCTestCode = ctestCode_t'(ChannelIndex + 1);

	nibble_t AdjustReg;
	discriMask_t MaskReg;
	logic Hit;

	assign Hit = (ChanOp.Channel == MyChannel);

	////////////////////////////////////////////////////////////
	// Adjust and mask registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			AdjustReg <= '0;
			// All discriminators enabled
			MaskReg <= '1;
		end else begin
			case (ChanOp.Kind)
				OpSetAdjust: if (Hit) AdjustReg <= ChanOp.Adjust;
				// Clear the pattern's zero bits
				OpMask: if (Hit) MaskReg <= MaskReg & ChanOp.Pattern;
				OpUnmask: if (Hit) MaskReg <= '1;
				// Applies to every slice
				OpUnmaskAll: MaskReg <= '1;
				default: ;
			endcase
		end
	end

	// ASIC shifts the adjust DAC LSB first, so swap the bit order
	assign Adjust = {AdjustReg[0], AdjustReg[1], AdjustReg[2], AdjustReg[3]};
	assign Mask = MaskReg;

	// Own bit of the one-hot CTest decode, 255 hits everyone
	assign CTestSelect = (CTestCode == MyCTestCode) || (CTestCode == `CTEST_ALL);

endmodule

// File: hw/CommandInterpreter.sv
`timescale 1ns/1ns
`include "CommandInterpreter_consts.svh"

module CommandInterpreter
	import CommandPkg::*;
	import SlowControlPkg::*;
(
	input logic Clk,
	input logic reset_n,
	// Host side
	input logic CommandWordEn,
	input commandWord_t CommandWord,
	output logic CommandFifoFull,
	// Global slow control
	output dacVth_t DacVth,
	output chipId_t ChipId,
	output chSelect_t DataoutChannelSelect,
	output chSelect_t TransmitOnChannelSelect,
	// Per-channel vectors, channel 0 in the low bits
	output logic [`NUM_CHANNELS-1:0] CTestChannel,
	output logic [4*`NUM_CHANNELS-1:0] ChannelAdjust,
	output logic [`NUM_DISCRI*`NUM_CHANNELS-1:0] DiscriminatorMask
);

	cmdStrobe_t Cmd;
	channelOp_t ChanOp;
	ctestCode_t CTestCode;

	////////////////////////////////////////////////////////////
	// FIFO and read FSM
	////////////////////////////////////////////////////////////

	CommandReader CommandReader_inst (
		.Clk(Clk),
		.reset_n(reset_n),
		.CommandWordEn(CommandWordEn),
		.CommandWord(CommandWord),
		.CommandFifoFull(CommandFifoFull),
		.Cmd(Cmd)
	);

	// Field registers and op broadcast
	CommandDecoder CommandDecoder_inst (
		.Clk(Clk),
		.reset_n(reset_n),
		.Cmd(Cmd),
		.DacVth(DacVth),
		.ChipId(ChipId),
		.DataoutChannelSelect(DataoutChannelSelect),
		.TransmitOnChannelSelect(TransmitOnChannelSelect),
		.CTestCode(CTestCode),
		.ChanOp(ChanOp)
	);

	////////////////////////////////////////////////////////////
	// Channel slices
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : gSlice
		// Each slice owns its nibble, its mask bits and its CTest bit
		ChannelSlice #(
			.ChannelIndex(i)
		) ChannelSlice_inst (
			.Clk(Clk),
			.reset_n(reset_n),
			.ChanOp(ChanOp),
			.CTestCode(CTestCode),
			.Adjust(ChannelAdjust[4*i +: 4]),
			.Mask(DiscriminatorMask[`NUM_DISCRI*i +: `NUM_DISCRI]),
			.CTestSelect(CTestChannel[i])
		);
	end

endmodule

// File: verif/CommandInterpreter_assertions.sv
`timescale 1ns/1ns
`include "CommandInterpreter_consts.svh"

module CommandInterpreterAssertions
	import CommandPkg::*;
(
	input logic Clk,
	input logic reset_n,
	input cmdStrobe_t Cmd,
	input logic CommandFifoFull,
	input logic FifoEmpty,
	input logic [`CMD_FIFO_AW-1:0] WrPtr,
	input logic [`CMD_FIFO_AW-1:0] RdPtr
);

	////////////////////////////////////////////////////////////
	// Reader strobe
	////////////////////////////////////////////////////////////

	// Reader pops at most every other cycle
	ValidNotBackToBack: assert property (
		@(posedge Clk) disable iff (!reset_n) Cmd.Valid |=> !Cmd.Valid
	) else $error("Cmd.Valid high on two consecutive cycles");

	// No strobe while held in reset
	ValidLowInReset: assert property (@(posedge Clk) !reset_n |-> !Cmd.Valid)
		else $error("Cmd.Valid high during reset");

	// Meeting pointers mean exactly one of full or empty
	FullNotEmpty: assert property (
		@(posedge Clk) disable iff (!reset_n)
			(WrPtr == RdPtr) |-> (CommandFifoFull != FifoEmpty)
	) else $error("FIFO pointers meet but full and empty disagree with them");

endmodule

bind CommandReader CommandInterpreterAssertions CommandInterpreterAssertions_inst (
	.Clk(Clk),
	.reset_n(reset_n),
	.Cmd(Cmd),
	.CommandFifoFull(CommandFifoFull),
	.FifoEmpty(FifoEmpty),
	.WrPtr(WrPtr),
	.RdPtr(RdPtr)
);

// File: verif/CommandInterpreterTb.sv
`timescale 1ns/1ns
`include "CommandInterpreter_consts.svh"

module CommandInterpreterTb
	import CommandPkg::*;
	import SlowControlPkg::*;
();

	// Kind of table entry, writes go to the FIFO and the rest are checks
	typedef enum logic [2:0] {
		ActWrite, ActDac, ActChipId, ActSelect, ActCTest, ActMask, ActAdjust, ActFull
	} action_t;

	// Word is the command for writes, otherwise it picks the DAC, select or channel
	typedef struct packed {
		action_t Action;
		commandWord_t Word;
		logic [`NUM_CHANNELS-1:0] Expected;
	} stimEntry_t;

	logic Clk;
	logic reset_n;
	logic CommandWordEn;
	commandWord_t CommandWord;
	logic CommandFifoFull;
	dacVth_t DacVth;
	chipId_t ChipId;
	chSelect_t DataoutChannelSelect;
	chSelect_t TransmitOnChannelSelect;
	logic [`NUM_CHANNELS-1:0] CTestChannel;
	logic [4*`NUM_CHANNELS-1:0] ChannelAdjust;
	logic [`NUM_DISCRI*`NUM_CHANNELS-1:0] DiscriminatorMask;

	stimEntry_t StimTable[$];
	// Expected adjust per channel, before the bit swap
	nibble_t AdjustModel[`NUM_CHANNELS];
	logic [15:0] LfsrState;
	int Pending;
	int CycleCount = 0;
	int CycleLimit = 0;
	int CheckCount;
	int ValueErrors;
	int OtherErrors;
	logic SawFull;

	CommandInterpreter CommandInterpreter_inst (.*);

	// 100 ns period
	always #50 Clk = ~Clk;

	// Run limit, armed once the table length is known
	always @(posedge Clk) begin
		CycleCount <= CycleCount + 1;
		if (CycleLimit > 0 && CycleCount >= CycleLimit) begin
			$display("Timeout: no result after %0d clock cycles", CycleCount);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] State);
		return State[0] ? ((State >> 1) ^ 16'hB400) : (State >> 1);
	endfunction

	// One step per bit taken, LSB first
	task automatic drawBits(input int Count, output logic [7:0] Value);
		Value = '0;
		for (int i = 0; i < Count; i++) begin
			Value[i] = LfsrState[0];
			LfsrState = lfsrNext(LfsrState);
		end
	endtask

	// Adjust nibble leaves the chip MSB and LSB swapped
	function automatic nibble_t reverseNibble(input nibble_t Value);
		nibble_t Result;
		for (int i = 0; i < 4; i++) begin
			Result[i] = Value[3 - i];
		end
		return Result;
	endfunction

	task automatic addEntry(input action_t Action, input commandWord_t Word,
			input logic [`NUM_CHANNELS-1:0] Expected);
		stimEntry_t Entry;
		Entry.Action = Action;
		Entry.Word = Word;
		Entry.Expected = Expected;
		StimTable.push_back(Entry);
	endtask

	// Every channel against the model
	task automatic addAdjustChecks();
		for (int c = 0; c < `NUM_CHANNELS; c++) begin
			addEntry(ActAdjust, 16'(c), 64'(reverseNibble(AdjustModel[c])));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic noteResult(input logic Ok, input string Msg);
		CheckCount++;
		if (!Ok) begin
			ValueErrors++;
			$display("ERR %0t: %s", $time, Msg);
		end
	endtask

	task automatic checkDac(input dacCode_t Actual, input dacCode_t Expected, input int Index);
		noteResult(Actual == Expected,
			$sformatf("DAC%0d is %h, expected %h", Index, Actual, Expected));
	endtask

	task automatic checkChipId(input chipId_t Actual, input chipId_t Expected);
		noteResult(Actual == Expected, $sformatf("ChipId is %h, expected %h", Actual, Expected));
	endtask

	task automatic checkSelect(input chSelect_t Actual, input chSelect_t Expected,
			input string Name);
		noteResult(Actual == Expected,
			$sformatf("%s is %0d, expected %0d", Name, Actual, Expected));
	endtask

	task automatic checkMask(input discriMask_t Actual, input discriMask_t Expected, input int Ch);
		noteResult(Actual == Expected,
			$sformatf("Mask of channel %0d is %b, expected %b", Ch, Actual, Expected));
	endtask

	task automatic checkAdjust(input nibble_t Actual, input nibble_t Expected, input int Ch);
		noteResult(Actual == Expected,
			$sformatf("Adjust of channel %0d is %h, expected %h", Ch, Actual, Expected));
	endtask

	task automatic checkCTest(input logic [`NUM_CHANNELS-1:0] Actual,
			input logic [`NUM_CHANNELS-1:0] Expected);
		noteResult(Actual == Expected,
			$sformatf("CTestChannel is %h, expected %h", Actual, Expected));
	endtask

	////////////////////////////////////////////////////////////
	// Bus driving
	////////////////////////////////////////////////////////////

	task automatic writeWord(input commandWord_t Word);
		@(posedge Clk);
		#5;
		// Hold off while the FIFO is full
		while (CommandFifoFull) begin
			SawFull = 1'b1;
			CommandWordEn = 1'b0;
			@(posedge Clk);
			#5;
		end
		CommandWordEn = 1'b1;
		CommandWord = Word;
		Pending++;
	endtask

	// Two cycles per queued word plus pipeline slack
	task automatic drainFifo();
		int Idle;
		if (Pending > 0) begin
			Idle = Pending * 2 + 4;
			@(posedge Clk);
			#5;
			CommandWordEn = 1'b0;
			repeat (Idle) @(posedge Clk);
			#5;
			Pending = 0;
		end
	endtask

	task automatic applyEntry(input stimEntry_t Entry);
		int Ch;
		Ch = int'(Entry.Word[5:0]);
		if (Entry.Action != ActWrite) begin
			drainFifo();
		end
		case (Entry.Action)
			ActWrite: writeWord(Entry.Word);
			ActDac: begin
				case (Entry.Word[1:0])
					2'd0: checkDac(DacVth.Dac0, dacCode_t'(Entry.Expected), 0);
					2'd1: checkDac(DacVth.Dac1, dacCode_t'(Entry.Expected), 1);
					default: checkDac(DacVth.Dac2, dacCode_t'(Entry.Expected), 2);
				endcase
			end
			ActChipId: checkChipId(ChipId, chipId_t'(Entry.Expected));
			ActSelect: begin
				if (Entry.Word[0]) begin
					checkSelect(TransmitOnChannelSelect, chSelect_t'(Entry.Expected),
						"TransmitOnChannelSelect");
				end else begin
					checkSelect(DataoutChannelSelect, chSelect_t'(Entry.Expected),
						"DataoutChannelSelect");
				end
			end
			ActCTest: checkCTest(CTestChannel, Entry.Expected);
			// Target gets the expected value, all others stay enabled
			ActMask: begin
				for (int c = 0; c < `NUM_CHANNELS; c++) begin
					checkMask(DiscriminatorMask[`NUM_DISCRI*c +: `NUM_DISCRI],
						(c == Ch) ? discriMask_t'(Entry.Expected) : {`NUM_DISCRI{1'b1}}, c);
				end
			end
			ActAdjust: checkAdjust(ChannelAdjust[4*Ch +: 4], nibble_t'(Entry.Expected), Ch);
			ActFull: begin
				if (!SawFull) begin
					$display("CommandFifoFull never went high during the burst");
					OtherErrors++;
				end
			end
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	task automatic buildTable();
		logic [7:0] Ch;
		logic [7:0] Val;
		commandWord_t FieldWords[15] = '{
			16'hC005, 16'hC01A, 16'hC023, 16'hC03F, 16'hC04F, 16'hC051, 16'hC062, 16'hC078,
			16'hC08E, 16'hC00C, 16'hA1B7, 16'hA1C4, 16'hA0B6, 16'hA0C1, 16'hA0C2};
		commandWord_t MaskWords[13] = '{
			16'hA2A5, 16'hA2B2, 16'hA2C5, 16'hA2D1, 16'hA2C6, 16'hA2D1, 16'hA2D2, 16'hA2D5,
			16'hA2C3, 16'hA2D1, 16'hA2A5, 16'hA2B0, 16'hA2D0};
		foreach (AdjustModel[c]) begin
			AdjustModel[c] = '0;
		end
		// Reset defaults
		for (int i = 0; i < 3; i++) begin
			addEntry(ActDac, 16'(i), 64'h0);
		end
		addEntry(ActChipId, 16'h0, 64'hA1);
		addEntry(ActSelect, 16'h0, 64'h3);
		addEntry(ActSelect, 16'h1, 64'h3);
		addEntry(ActCTest, 16'h0, 64'h0);
		addEntry(ActMask, 16'h0, 64'h7);
		addAdjustChecks();
		// Nibble writes, C00 written twice so the second value wins
		foreach (FieldWords[i]) begin
			addEntry(ActWrite, FieldWords[i], '0);
		end
		addEntry(ActDac, 16'h0, 64'h3AC);
		addEntry(ActDac, 16'h1, 64'h1FF);
		addEntry(ActDac, 16'h2, 64'h282);
		addEntry(ActChipId, 16'h0, 64'h47);
		addEntry(ActSelect, 16'h0, 64'h2);
		addEntry(ActSelect, 16'h1, 64'h2);
		// CTest codes 1, 64, 65, 255 then 0
		addEntry(ActWrite, 16'hA161, '0);
		addEntry(ActCTest, 16'h0, 64'h1);
		addEntry(ActWrite, 16'hA160, '0);
		addEntry(ActWrite, 16'hA174, '0);
		addEntry(ActCTest, 16'h0, 64'h8000_0000_0000_0000);
		addEntry(ActWrite, 16'hA161, '0);
		addEntry(ActCTest, 16'h0, 64'h0);
		addEntry(ActWrite, 16'hA16F, '0);
		addEntry(ActWrite, 16'hA17F, '0);
		addEntry(ActCTest, 16'h0, '1);
		addEntry(ActWrite, 16'hA160, '0);
		addEntry(ActWrite, 16'hA170, '0);
		addEntry(ActCTest, 16'h0, 64'h0);
		// Random adjust writes
		for (int i = 0; i < 8; i++) begin
			drawBits(6, Ch);
			drawBits(4, Val);
			AdjustModel[Ch[5:0]] = Val[3:0];
			addEntry(ActWrite, {`ADJUST_PREFIX, Ch[5:0], Val[3:0]}, '0);
		end
		addAdjustChecks();
		// Channel 37, mask 5 then 6, unmask, ignored code, mask 3, unmask all
		for (int i = 0; i < 4; i++) begin
			addEntry(ActWrite, MaskWords[i], '0);
		end
		addEntry(ActMask, 16'd37, 64'h5);
		addEntry(ActWrite, MaskWords[4], '0);
		addEntry(ActWrite, MaskWords[5], '0);
		addEntry(ActMask, 16'd37, 64'h4);
		addEntry(ActWrite, MaskWords[6], '0);
		addEntry(ActWrite, MaskWords[7], '0);
		addEntry(ActMask, 16'd37, 64'h7);
		addEntry(ActWrite, MaskWords[8], '0);
		addEntry(ActWrite, MaskWords[9], '0);
		addEntry(ActMask, 16'd37, 64'h3);
		// Unmask all issued with another channel selected
		for (int i = 10; i < 13; i++) begin
			addEntry(ActWrite, MaskWords[i], '0);
		end
		addEntry(ActMask, 16'd37, 64'h7);
		// Burst of 40, channels 0 to 19 written twice
		for (int i = 0; i < 40; i++) begin
			drawBits(4, Val);
			AdjustModel[i % 20] = Val[3:0];
			addEntry(ActWrite, {`ADJUST_PREFIX, 6'(i % 20), Val[3:0]}, '0);
		end
		addEntry(ActFull, 16'h0, 64'h0);
		addAdjustChecks();
	endtask

	initial begin
		Clk = 1'b0;
		reset_n = 1'b0;
		CommandWordEn = 1'b0;
		CommandWord = '0;
		LfsrState = 16'd64;
		Pending = 0;
		CheckCount = 0;
		ValueErrors = 0;
		OtherErrors = 0;
		SawFull = 1'b0;
		buildTable();
		CycleLimit = StimTable.size() * 8 + 200;
		repeat (10) @(posedge Clk);
		#5;
		reset_n = 1'b1;
		if (CommandFifoFull) begin
			$display("CommandFifoFull is high right after reset");
			OtherErrors++;
		end
		foreach (StimTable[i]) begin
			applyEntry(StimTable[i]);
		end
		drainFifo();
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			CheckCount, ValueErrors, OtherErrors);
		if (ValueErrors == 0 && OtherErrors == 0 && CheckCount > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+hw
hw/CommandPkg.sv
hw/SlowControlPkg.sv
hw/CommandReader.sv
hw/CommandDecoder.sv
hw/ChannelSlice.sv
hw/CommandInterpreter.sv
verif/CommandInterpreter_assertions.sv
verif/CommandInterpreterTb.sv

// File: Makefile
TOP = CommandInterpreterTb

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

# Pass only when the testbench prints the pass line
sim: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
